//--- kdtree_ctrl_config.svh
`ifndef KDTREE_CTRL_CONFIG_SVH
`define KDTREE_CTRL_CONFIG_SVH

// tree geometry
`define KD_NUM_LEAVES   64
`define KD_NUM_NODES    63

// words per leaf, one bank per word
`define KD_LEAF_SIZE    8

// 26 x 19 query patches
`define KD_NUM_QUERYS   494

// best-array depth, one bank per rank
`define KD_K            4

// memory address widths
`define KD_LEAF_ADDRW   6
`define KD_QUERY_ADDRW  9

// aggregator fetch widths per load sub-phase
`define KD_WIDTH_NODE   3'd1
`define KD_WIDTH_LEAF   3'd5
`define KD_WIDTH_QUERY  3'd4

`endif

//--- kdtree_ctrl_pkg.sv
`include "kdtree_ctrl_config.svh"

package kdtree_ctrl_pkg;

    // fetch-width request to the aggregation receiver
    typedef struct packed {
        logic       change;
        logic [2:0] width;
    } agg_ctrl_t;

    // query-patch memory write port, active-low selects
    typedef struct packed {
        logic                        csb;
        logic                        web;
        logic [`KD_QUERY_ADDRW-1:0]  addr;
    } qp_wr_t;

    // leaf memory write port, one select bit per bank
    typedef struct packed {
        logic [`KD_LEAF_SIZE-1:0]   csb;
        logic [`KD_LEAF_SIZE-1:0]   web;
        logic [`KD_LEAF_ADDRW-1:0]  addr;
    } leaf_wr_t;

    // best-array read port, one select bit per rank bank
    typedef struct packed {
        logic [`KD_K-1:0]            csb;
        logic [`KD_QUERY_ADDRW-1:0]  addr;
    } best_rd_t;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_NODES,
        LOAD_LEAVES,
        LOAD_QUERYS
    } load_phase_t;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_LOAD,
        MODE_SEND
    } mode_t;

endpackage

//--- kdtree_main_fsm.sv
`timescale 1ns/1ps

module kdtree_main_fsm import kdtree_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic load_kdtree,
    input  logic send_best_arr,
    input  logic load_done,
    input  logic send_done,
    output logic load_start,
    output logic send_start
);

    mode_t mode;
    mode_t mode_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_IDLE;
        end else begin
            mode <= mode_next;
        end
    end

    always_comb begin
        mode_next  = mode;
        load_start = 1'b0;
        send_start = 1'b0;

        unique case (mode)
            MODE_IDLE: begin
                // readout wins when both requests are up
                if (send_best_arr) begin
                    send_start = 1'b1;
                    mode_next  = MODE_SEND;
                end else if (load_kdtree) begin
                    load_start = 1'b1;
                    mode_next  = MODE_LOAD;
                end
            end

            MODE_LOAD: begin
                if (load_done) begin
                    mode_next = MODE_IDLE;
                end
            end

            MODE_SEND: begin
                if (send_done) begin
                    mode_next = MODE_IDLE;
                end
            end

            default: mode_next = MODE_IDLE;
        endcase
    end

endmodule

//--- kdtree_load_seq.sv
`timescale 1ns/1ps

`include "kdtree_ctrl_config.svh"

module kdtree_load_seq import kdtree_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_start,
    input  logic      agg_receiver_enq,
    output logic      agg_receiver_full_n,
    output agg_ctrl_t agg_ctrl,
    output logic      int_node_fsm_enable,
    output leaf_wr_t  leaf_wr,
    output qp_wr_t    qp_wr,
    output logic      load_done
);

    localparam int BANK_BITS = $clog2(`KD_LEAF_SIZE);

    load_phase_t              phase;
    load_phase_t              phase_next;
    logic [15:0]              counter;
    logic [15:0]              counter_limit;
    logic                     counter_last;
    logic                     xfer;
    logic [`KD_LEAF_SIZE-1:0] bank_sel;

    // the receiver may push for the whole load
    assign agg_receiver_full_n = (phase != LOAD_IDLE);
    assign xfer                = agg_receiver_full_n & agg_receiver_enq;

    always_comb begin
        unique case (phase)
            LOAD_NODES:  counter_limit = 16'(`KD_NUM_NODES - 1);
            LOAD_LEAVES: counter_limit = 16'(`KD_NUM_LEAVES * `KD_LEAF_SIZE - 1);
            LOAD_QUERYS: counter_limit = 16'(`KD_NUM_QUERYS - 1);
            default:     counter_limit = '0;
        endcase
    end

    assign counter_last = (counter == counter_limit);

    // low counter bits pick the leaf bank, active low
    always_comb begin
        bank_sel                           = '1;
        bank_sel[counter[BANK_BITS-1:0]]   = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= LOAD_IDLE;
            counter <= '0;
        end else begin
            phase <= phase_next;
            if (xfer) begin
                counter <= counter_last ? '0 : counter + 16'd1;
            end
        end
    end

    always_comb begin
        phase_next          = phase;
        agg_ctrl            = '0;
        int_node_fsm_enable = 1'b0;
        load_done           = 1'b0;
        leaf_wr.csb         = '1;
        leaf_wr.web         = '1;
        leaf_wr.addr        = '0;
        qp_wr.csb           = 1'b1;
        qp_wr.web           = 1'b1;
        qp_wr.addr          = '0;

        unique case (phase)
            LOAD_IDLE: begin
                if (load_start) begin
                    agg_ctrl.change = 1'b1;
                    agg_ctrl.width  = `KD_WIDTH_NODE;
                    phase_next      = LOAD_NODES;
                end
            end

            LOAD_NODES: begin
                // node words go straight to the internal-node FSM
                int_node_fsm_enable = 1'b1;
                if (xfer && counter_last) begin
                    agg_ctrl.change = 1'b1;
                    agg_ctrl.width  = `KD_WIDTH_LEAF;
                    phase_next      = LOAD_LEAVES;
                end
            end

            LOAD_LEAVES: begin
                if (xfer) begin
                    leaf_wr.csb  = bank_sel;
                    leaf_wr.web  = bank_sel;
                    leaf_wr.addr = counter[BANK_BITS +: `KD_LEAF_ADDRW];
                    if (counter_last) begin
                        agg_ctrl.change = 1'b1;
                        agg_ctrl.width  = `KD_WIDTH_QUERY;
                        phase_next      = LOAD_QUERYS;
                    end
                end
            end

            LOAD_QUERYS: begin
                if (xfer) begin
                    qp_wr.csb  = 1'b0;
                    qp_wr.web  = 1'b0;
                    qp_wr.addr = counter[`KD_QUERY_ADDRW-1:0];
                    if (counter_last) begin
                        load_done  = 1'b1;
                        phase_next = LOAD_IDLE;
                    end
                end
            end

            default: phase_next = LOAD_IDLE;
        endcase
    end

endmodule

//--- best_arr_readout.sv
`timescale 1ns/1ps

`include "kdtree_ctrl_config.svh"

module best_arr_readout import kdtree_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     send_start,
    input  logic     out_fifo_wfull_n,
    output best_rd_t best_rd,
    output logic     out_fifo_wenq,
    output logic     send_done
);

    logic                       active;
    logic [`KD_QUERY_ADDRW-1:0] rd_cnt;
    logic                       rd_en;

    // one read per free slot, never back to back with a pending enqueue
    assign rd_en     = active & ~out_fifo_wenq & out_fifo_wfull_n;
    assign send_done = rd_en & (rd_cnt == `KD_QUERY_ADDRW'(`KD_NUM_QUERYS - 1));

    // only rank 0 of each query is read out
    assign best_rd.csb  = rd_en ? {{(`KD_K-1){1'b1}}, 1'b0} : '1;
    assign best_rd.addr = rd_en ? rd_cnt : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active        <= 1'b0;
            rd_cnt        <= '0;
            out_fifo_wenq <= 1'b0;
        end else begin
            out_fifo_wenq <= rd_en;
            if (send_start) begin
                active <= 1'b1;
                rd_cnt <= '0;
            end else if (send_done) begin
                active <= 1'b0;
                rd_cnt <= '0;
            end else if (rd_en) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

//--- kdtree_ctrl.sv
`timescale 1ns/1ps

module kdtree_ctrl import kdtree_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_kdtree,
    input  logic      send_best_arr,
    input  logic      agg_receiver_enq,
    output logic      agg_receiver_full_n,
    output agg_ctrl_t agg_ctrl,
    output logic      int_node_fsm_enable,
    output qp_wr_t    qp_wr,
    output leaf_wr_t  leaf_wr,
    output best_rd_t  best_rd,
    output logic      out_fifo_wenq,
    input  logic      out_fifo_wfull_n
);

    logic load_start;
    logic send_start;
    logic load_done;
    logic send_done;

    kdtree_main_fsm main_fsm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_kdtree   (load_kdtree),
        .send_best_arr (send_best_arr),
        .load_done     (load_done),
        .send_done     (send_done),
        .load_start    (load_start),
        .send_start    (send_start)
    );

    kdtree_load_seq load_seq_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .load_start          (load_start),
        .agg_receiver_enq    (agg_receiver_enq),
        .agg_receiver_full_n (agg_receiver_full_n),
        .agg_ctrl            (agg_ctrl),
        .int_node_fsm_enable (int_node_fsm_enable),
        .leaf_wr             (leaf_wr),
        .qp_wr               (qp_wr),
        .load_done           (load_done)
    );

    best_arr_readout readout_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .send_start       (send_start),
        .out_fifo_wfull_n (out_fifo_wfull_n),
        .best_rd          (best_rd),
        .out_fifo_wenq    (out_fifo_wenq),
        .send_done        (send_done)
    );

endmodule

//--- kdtree_ctrl_checker.sv
`timescale 1ns/1ps

module kdtree_ctrl_checker import kdtree_ctrl_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      agg_receiver_full_n,
    input agg_ctrl_t agg_ctrl,
    input leaf_wr_t  leaf_wr,
    input qp_wr_t    qp_wr,
    input logic      out_fifo_wenq
);

    // leaf words go to exactly one bank
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(~leaf_wr.csb))
        else $error("more than one leaf bank selected");

    assert property (@(posedge clk) disable iff (!rst_n)
        out_fifo_wenq |=> !out_fifo_wenq)
        else $error("output FIFO enqueue high on two consecutive cycles");

    // memory writes only while the receiver is open
    assert property (@(posedge clk) disable iff (!rst_n)
        !agg_receiver_full_n |-> ((&leaf_wr.csb) && qp_wr.csb))
        else $error("memory select active while the receiver is closed");

    assert property (@(posedge clk) disable iff (!rst_n)
        agg_ctrl.change |=> !agg_ctrl.change)
        else $error("fetch-width change held longer than one cycle");

endmodule

bind kdtree_ctrl kdtree_ctrl_checker kdtree_ctrl_checker_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .agg_receiver_full_n (agg_receiver_full_n),
    .agg_ctrl            (agg_ctrl),
    .leaf_wr             (leaf_wr),
    .qp_wr               (qp_wr),
    .out_fifo_wenq       (out_fifo_wenq)
);

//--- kdtree_ctrl_tb.sv
`timescale 1ns/1ps

`include "kdtree_ctrl_config.svh"

module kdtree_ctrl_tb import kdtree_ctrl_pkg::*; ();

    localparam int NODE_WORDS   = `KD_NUM_NODES;
    localparam int LEAF_WORDS   = `KD_NUM_LEAVES * `KD_LEAF_SIZE;
    localparam int QUERY_WORDS  = `KD_NUM_QUERYS;
    localparam int TOTAL_WORDS  = NODE_WORDS + LEAF_WORDS + QUERY_WORDS;
    localparam int LOAD_TIMEOUT = 8 * TOTAL_WORDS;
    localparam int READ_TIMEOUT = 20 * QUERY_WORDS;

    logic      clk;
    logic      rst_n;
    logic      load_kdtree;
    logic      send_best_arr;
    logic      agg_receiver_enq;
    logic      agg_receiver_full_n;
    agg_ctrl_t agg_ctrl;
    logic      int_node_fsm_enable;
    qp_wr_t    qp_wr;
    leaf_wr_t  leaf_wr;
    best_rd_t  best_rd;
    logic      out_fifo_wenq;
    logic      out_fifo_wfull_n;
    integer    seed;

    kdtree_ctrl kdtree_ctrl_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .load_kdtree         (load_kdtree),
        .send_best_arr       (send_best_arr),
        .agg_receiver_enq    (agg_receiver_enq),
        .agg_receiver_full_n (agg_receiver_full_n),
        .agg_ctrl            (agg_ctrl),
        .int_node_fsm_enable (int_node_fsm_enable),
        .qp_wr               (qp_wr),
        .leaf_wr             (leaf_wr),
        .best_rd             (best_rd),
        .out_fifo_wenq       (out_fifo_wenq),
        .out_fifo_wfull_n    (out_fifo_wfull_n)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic check_reset_state(input string test_name);
        @(negedge clk);
        check_value(test_name, "full_n", 0, agg_receiver_full_n);
        check_value(test_name, "change", 0, agg_ctrl.change);
        check_value(test_name, "int_node_fsm_enable", 0, int_node_fsm_enable);
        check_value(test_name, "wenq", 0, out_fifo_wenq);
        check_value(test_name, "leaf csb", 8'hff, leaf_wr.csb);
        check_value(test_name, "leaf web", 8'hff, leaf_wr.web);
        check_value(test_name, "qp csb", 1, qp_wr.csb);
        check_value(test_name, "qp web", 1, qp_wr.web);
        check_value(test_name, "best csb", 4'hf, best_rd.csb);
    endtask

    // expected outputs for load word t, in a transfer or a gap cycle
    task automatic check_load_outputs(input string test_name, input int t, input logic xfer);
        logic                       exp_change;
        logic [2:0]                 exp_width;
        logic [`KD_LEAF_SIZE-1:0]   exp_leaf_sel;
        logic [`KD_LEAF_ADDRW-1:0]  exp_leaf_addr;
        logic                       exp_qp_sel;
        logic [`KD_QUERY_ADDRW-1:0] exp_qp_addr;
        int                         n;
        exp_change    = 1'b0;
        exp_width     = '0;
        exp_leaf_sel  = '1;
        exp_leaf_addr = '0;
        exp_qp_sel    = 1'b1;
        exp_qp_addr   = '0;
        if (xfer && t < NODE_WORDS) begin
            if (t == NODE_WORDS - 1) begin
                exp_change = 1'b1;
                exp_width  = `KD_WIDTH_LEAF;
            end
        end else if (xfer && t < NODE_WORDS + LEAF_WORDS) begin
            n             = t - NODE_WORDS;
            exp_leaf_sel  = ~(`KD_LEAF_SIZE'(1) << (n % `KD_LEAF_SIZE));
            exp_leaf_addr = `KD_LEAF_ADDRW'(n / `KD_LEAF_SIZE);
            if (n == LEAF_WORDS - 1) begin
                exp_change = 1'b1;
                exp_width  = `KD_WIDTH_QUERY;
            end
        end else if (xfer) begin
            exp_qp_sel  = 1'b0;
            exp_qp_addr = `KD_QUERY_ADDRW'(t - NODE_WORDS - LEAF_WORDS);
        end
        check_value(test_name, "full_n", 1, agg_receiver_full_n);
        check_value(test_name, "change", exp_change, agg_ctrl.change);
        if (exp_change) begin
            check_value(test_name, "width", exp_width, agg_ctrl.width);
        end
        check_value(test_name, "int_node_fsm_enable", t < NODE_WORDS, int_node_fsm_enable);
        check_value(test_name, "leaf csb", exp_leaf_sel, leaf_wr.csb);
        check_value(test_name, "leaf web", exp_leaf_sel, leaf_wr.web);
        if (!(&exp_leaf_sel)) begin
            check_value(test_name, "leaf addr", exp_leaf_addr, leaf_wr.addr);
        end
        check_value(test_name, "qp csb", exp_qp_sel, qp_wr.csb);
        check_value(test_name, "qp web", exp_qp_sel, qp_wr.web);
        if (!exp_qp_sel) begin
            check_value(test_name, "qp addr", exp_qp_addr, qp_wr.addr);
        end
    endtask

    task automatic load_tree(input string test_name, input logic use_gaps);
        int t;
        int cycles;
        @(posedge clk);
        #2;
        load_kdtree      = 1'b1;
        agg_receiver_enq = 1'b0;
        @(negedge clk);
        check_value(test_name, "start change", 1, agg_ctrl.change);
        check_value(test_name, "start width", `KD_WIDTH_NODE, agg_ctrl.width);
        check_value(test_name, "full_n at start", 0, agg_receiver_full_n);
        t      = 0;
        cycles = 0;
        while (t < TOTAL_WORDS) begin
            if (cycles == LOAD_TIMEOUT) begin
                report_timeout({test_name, ": load did not take all words in time"});
            end
            @(posedge clk);
            #2;
            load_kdtree      = 1'b0;
            agg_receiver_enq = use_gaps ? (($random(seed) & 3) != 0) : 1'b1;
            @(negedge clk);
            check_load_outputs(test_name, t, agg_receiver_enq);
            if (agg_receiver_enq) begin
                t++;
            end
            cycles++;
        end
        @(posedge clk);
        #2;
        agg_receiver_enq = 1'b0;
        @(negedge clk);
        check_value(test_name, "full_n after load", 0, agg_receiver_full_n);
    endtask

    task automatic read_best_array(input string test_name, input logic both_requests);
        int   reads;
        int   cycles;
        logic exp_wenq;
        logic exp_read;
        @(posedge clk);
        #2;
        send_best_arr    = 1'b1;
        load_kdtree      = both_requests;
        out_fifo_wfull_n = ($random(seed) & 3) != 0;
        @(negedge clk);
        check_value(test_name, "change at start", 0, agg_ctrl.change);
        check_value(test_name, "best csb at start", 4'hf, best_rd.csb);
        reads    = 0;
        cycles   = 0;
        exp_wenq = 1'b0;
        while (reads < QUERY_WORDS || exp_wenq) begin
            if (cycles == READ_TIMEOUT) begin
                report_timeout({test_name, ": readout did not finish in time"});
            end
            @(posedge clk);
            #2;
            send_best_arr    = 1'b0;
            load_kdtree      = 1'b0;
            out_fifo_wfull_n = ($random(seed) & 3) != 0;
            @(negedge clk);
            // a read needs a free FIFO and no enqueue pending
            exp_read = (reads < QUERY_WORDS) && !exp_wenq && out_fifo_wfull_n;
            check_value(test_name, "wenq", exp_wenq, out_fifo_wenq);
            check_value(test_name, "best csb", exp_read ? 4'b1110 : 4'b1111, best_rd.csb);
            if (exp_read) begin
                check_value(test_name, "best addr", reads, best_rd.addr);
            end
            check_value(test_name, "change", 0, agg_ctrl.change);
            check_value(test_name, "full_n", 0, agg_receiver_full_n);
            if (exp_read) begin
                reads++;
            end
            exp_wenq = exp_read;
            cycles++;
        end
        @(posedge clk);
        #2;
        out_fifo_wfull_n = 1'b1;
        @(negedge clk);
        check_value(test_name, "wenq after readout", 0, out_fifo_wenq);
        check_value(test_name, "best csb after readout", 4'hf, best_rd.csb);
    endtask

    initial begin
        seed             = 32'h4913;
        clk              = 1'b0;
        rst_n            = 1'b0;
        load_kdtree      = 1'b0;
        send_best_arr    = 1'b0;
        agg_receiver_enq = 1'b0;
        out_fifo_wfull_n = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset_state("after_reset");
        load_tree("load_full_rate", 1'b0);
        load_tree("load_random_gaps", 1'b1);
        read_best_array("readout_backpressure", 1'b0);
        read_best_array("both_requests", 1'b1);
        load_tree("load_after_both", 1'b0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- kdtree_ctrl.f
+incdir+.
kdtree_ctrl_pkg.sv
kdtree_main_fsm.sv
kdtree_load_seq.sv
best_arr_readout.sv
kdtree_ctrl.sv
kdtree_ctrl_checker.sv
kdtree_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module kdtree_ctrl_tb -f kdtree_ctrl.f
status=0
./obj_dir/Vkdtree_ctrl_tb > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without passing, status $status"
    exit 1
fi
